/* hdl/regfile_pkg.sv */
package regfile_pkg;

   // Default sizes; the top level passes them down as module parameters.
   localparam int DATA_W_DEF   = 16;
   localparam int NUM_REGS_DEF = 16;

   localparam int REG_ADDR_W = $clog2(NUM_REGS_DEF);

   typedef enum logic [1:0]
   {
      OP_ADD   = 2'd0,
      OP_SUB   = 2'd1,
      OP_XOR   = 2'd2,
      OP_LOADI = 2'd3
   } op_e;

   // One host command of 30 bits.
   typedef struct packed
   {
      op_e                   op;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [DATA_W_DEF-1:0] imm;
   } cmd_t;

   // One result record of 20 bits.
   typedef struct packed
   {
      logic [REG_ADDR_W-1:0] rd;
      logic [DATA_W_DEF-1:0] value;
   } result_t;

   // Count of credits or free slots for depths up to 15.
   typedef logic [3:0] credit_cnt_t;

endpackage

/* hdl/reg_mem_multiport.sv */
`timescale 1ns/1ps

module reg_mem_multiport
#(
   parameter int DATA_W      = regfile_pkg::DATA_W_DEF,
   parameter int NUM_REGS    = regfile_pkg::NUM_REGS_DEF,
   parameter int READ_PORTS  = 2,
   parameter int WRITE_PORTS = 1
)
(
   input  logic                                          w_clk_i,
   input  logic                                          arst_n_i,

   input  logic [WRITE_PORTS-1:0]                        w_v_i,
   input  logic [WRITE_PORTS-1:0][$clog2(NUM_REGS)-1:0]  w_addr_i,
   input  logic [WRITE_PORTS-1:0][DATA_W-1:0]            w_data_i,

   input  logic [READ_PORTS-1:0][$clog2(NUM_REGS)-1:0]   r_addr_i,
   output logic [READ_PORTS-1:0][DATA_W-1:0]             r_data_o
);

   localparam int ADDR_W = $clog2(NUM_REGS);

   logic [DATA_W-1:0] mem [NUM_REGS];

   // Reads are purely combinational, so a write shows up on the read
   // ports right after the edge that performs it.
   for (genvar i = 0; i < READ_PORTS; i++)
   begin : g_read
      assign r_data_o[i] = mem[r_addr_i[i]];
   end

   // All write ports share one process. If two ports ever hit the same
   // address, the higher port index wins.
   always_ff @(posedge w_clk_i)
   begin
      for (int i = 0; i < WRITE_PORTS; i++)
      begin
         // Writes are ignored while the engine is held in reset.
         if (arst_n_i && w_v_i[i])
         begin
            mem[w_addr_i[i][ADDR_W-1:0]] <= w_data_i[i];
         end
      end
   end

endmodule

/* hdl/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo
#(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
)
(
   input  logic     w_clk_i,
   input  logic     arst_n_i,

   input  logic     push_i,
   input  payload_t data_i,

   input  logic     pop_i,
   output logic     valid_o,
   output payload_t data_o,

   output logic     credit_o
);

   import regfile_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   credit_cnt_t      count;
   logic             do_push;
   logic             do_pop;

   assign valid_o = (count != '0);
   assign data_o  = mem[rd_ptr];

   // A pop on an empty buffer is dropped.
   assign do_pop  = pop_i && valid_o;
   assign do_push = push_i;

   always_ff @(posedge w_clk_i)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge w_clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end

         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase

         // Each entry that leaves hands one slot back to the sender.
         credit_o <= do_pop;
      end
   end

endmodule

/* hdl/cmd_issue.sv */
`timescale 1ns/1ps

module cmd_issue
#(
   parameter int DATA_W    = regfile_pkg::DATA_W_DEF,
   parameter int NUM_REGS  = regfile_pkg::NUM_REGS_DEF,
   parameter int RES_DEPTH = 4
)
(
   input  logic                                w_clk_i,
   input  logic                                arst_n_i,

   input  logic                                cmd_valid_i,
   input  regfile_pkg::cmd_t                   cmd_i,
   output logic                                cmd_pop_o,

   output logic [1:0][$clog2(NUM_REGS)-1:0]    rd_addr_o,
   input  logic [1:0][DATA_W-1:0]              rd_data_i,

   output logic                                wr_v_o,
   output logic [$clog2(NUM_REGS)-1:0]         wr_addr_o,
   output logic [DATA_W-1:0]                   wr_data_o,

   output logic                                res_push_o,
   output regfile_pkg::result_t                res_o,
   input  logic                                res_credit_i
);

   import regfile_pkg::*;

   localparam int ADDR_W = $clog2(NUM_REGS);

   credit_cnt_t       free_cnt;
   logic              issue;
   logic [DATA_W-1:0] alu_result;

   // A command goes out only when the result buffer has room for its record.
   assign issue = cmd_valid_i && (free_cnt != '0);

   assign rd_addr_o[0] = cmd_i.rs1[ADDR_W-1:0];
   assign rd_addr_o[1] = cmd_i.rs2[ADDR_W-1:0];

   always_comb
   begin
      case (cmd_i.op)
         OP_ADD:  alu_result = rd_data_i[0] + rd_data_i[1];
         OP_SUB:  alu_result = rd_data_i[0] - rd_data_i[1];
         OP_XOR:  alu_result = rd_data_i[0] ^ rd_data_i[1];
         default: alu_result = DATA_W'(cmd_i.imm);
      endcase
   end

   // Pop, writeback and result push all happen at the same edge.
   assign cmd_pop_o  = issue;
   assign wr_v_o     = issue;
   assign wr_addr_o  = cmd_i.rd[ADDR_W-1:0];
   assign wr_data_o  = alu_result;
   assign res_push_o = issue;

   assign res_o.rd    = cmd_i.rd;
   assign res_o.value = DATA_W_DEF'(alu_result);

   // Free slots in the result buffer come back one per res_credit_i pulse.
   always_ff @(posedge w_clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         free_cnt <= credit_cnt_t'(RES_DEPTH);
      end
      else
      begin
         case ({issue, res_credit_i})
            2'b10:   free_cnt <= free_cnt - 1'b1;
            2'b01:   free_cnt <= free_cnt + 1'b1;
            default: free_cnt <= free_cnt;
         endcase
      end
   end

endmodule

/* hdl/result_sender.sv */
`timescale 1ns/1ps

module result_sender
#(
   parameter int RES_DEPTH   = 4,
   parameter int OUT_CREDITS = 2
)
(
   input  logic                 w_clk_i,
   input  logic                 arst_n_i,

   input  logic                 res_push_i,
   input  regfile_pkg::result_t res_i,
   output logic                 res_credit_o,

   output logic                 result_valid_o,
   output regfile_pkg::result_t result_o,
   input  logic                 result_credit_i
);

   import regfile_pkg::*;

   credit_cnt_t out_credits;
   logic        buf_valid;
   result_t     buf_head;
   logic        send;

   credit_fifo
   #(
      .payload_t (result_t),
      .DEPTH     (RES_DEPTH)
   )
   res_buf_i
   (
      .w_clk_i  (w_clk_i),
      .arst_n_i (arst_n_i),
      .push_i   (res_push_i),
      .data_i   (res_i),
      .pop_i    (send),
      .valid_o  (buf_valid),
      .data_o   (buf_head),
      .credit_o (res_credit_o)
   );

   // One record per cycle while the consumer still has room.
   assign send = buf_valid && (out_credits != '0);

   always_ff @(posedge w_clk_i)
   begin
      if (send)
      begin
         result_o <= buf_head;
      end
   end

   always_ff @(posedge w_clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         out_credits    <= credit_cnt_t'(OUT_CREDITS);
         result_valid_o <= 1'b0;
      end
      else
      begin
         result_valid_o <= send;
         case ({send, result_credit_i})
            2'b10:   out_credits <= out_credits - 1'b1;
            2'b01:   out_credits <= out_credits + 1'b1;
            default: out_credits <= out_credits;
         endcase
      end
   end

endmodule

/* hdl/regfile_engine_top.sv */
`timescale 1ns/1ps

module regfile_engine_top
#(
   parameter int DATA_W      = regfile_pkg::DATA_W_DEF,
   parameter int NUM_REGS    = regfile_pkg::NUM_REGS_DEF,
   parameter int CMD_DEPTH   = 4,
   parameter int RES_DEPTH   = 4,
   parameter int OUT_CREDITS = 2
)
(
   input  logic                 w_clk_i,
   input  logic                 arst_n_i,

   input  logic                 cmd_valid_i,
   input  regfile_pkg::cmd_t    cmd_i,
   output logic                 cmd_credit_o,

   output logic                 result_valid_o,
   output regfile_pkg::result_t result_o,
   input  logic                 result_credit_i
);

   import regfile_pkg::*;

   localparam int ADDR_W = $clog2(NUM_REGS);

   logic                        cmd_valid;
   cmd_t                        cmd_head;
   logic                        cmd_pop;
   logic [1:0][ADDR_W-1:0]      rd_addr;
   logic [1:0][DATA_W-1:0]      rd_data;
   logic [0:0]                  wr_v;
   logic [0:0][ADDR_W-1:0]      wr_addr;
   logic [0:0][DATA_W-1:0]      wr_data;
   logic                        res_push;
   result_t                     res_data;
   logic                        res_credit;

   credit_fifo
   #(
      .payload_t (cmd_t),
      .DEPTH     (CMD_DEPTH)
   )
   cmd_buf_i
   (
      .w_clk_i  (w_clk_i),
      .arst_n_i (arst_n_i),
      .push_i   (cmd_valid_i),
      .data_i   (cmd_i),
      .pop_i    (cmd_pop),
      .valid_o  (cmd_valid),
      .data_o   (cmd_head),
      .credit_o (cmd_credit_o)
   );

   cmd_issue
   #(
      .DATA_W    (DATA_W),
      .NUM_REGS  (NUM_REGS),
      .RES_DEPTH (RES_DEPTH)
   )
   issue_i
   (
      .w_clk_i      (w_clk_i),
      .arst_n_i     (arst_n_i),
      .cmd_valid_i  (cmd_valid),
      .cmd_i        (cmd_head),
      .cmd_pop_o    (cmd_pop),
      .rd_addr_o    (rd_addr),
      .rd_data_i    (rd_data),
      .wr_v_o       (wr_v[0]),
      .wr_addr_o    (wr_addr[0]),
      .wr_data_o    (wr_data[0]),
      .res_push_o   (res_push),
      .res_o        (res_data),
      .res_credit_i (res_credit)
   );

   reg_mem_multiport
   #(
      .DATA_W      (DATA_W),
      .NUM_REGS    (NUM_REGS),
      .READ_PORTS  (2),
      .WRITE_PORTS (1)
   )
   regs_i
   (
      .w_clk_i  (w_clk_i),
      .arst_n_i (arst_n_i),
      .w_v_i    (wr_v),
      .w_addr_i (wr_addr),
      .w_data_i (wr_data),
      .r_addr_i (rd_addr),
      .r_data_o (rd_data)
   );

   result_sender
   #(
      .RES_DEPTH   (RES_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   )
   sender_i
   (
      .w_clk_i         (w_clk_i),
      .arst_n_i        (arst_n_i),
      .res_push_i      (res_push),
      .res_i           (res_data),
      .res_credit_o    (res_credit),
      .result_valid_o  (result_valid_o),
      .result_o        (result_o),
      .result_credit_i (result_credit_i)
   );

endmodule

/* testbench/regfile_engine_sva.sv */
`timescale 1ns/1ps

module regfile_engine_sva
#(
   parameter int NUM_REGS    = regfile_pkg::NUM_REGS_DEF,
   parameter int CMD_DEPTH   = 4,
   parameter int OUT_CREDITS = 2
)
(
   input logic                             w_clk_i,
   input logic                             arst_n_i,
   input logic                             cmd_push_i,
   input logic                             cmd_pop_i,
   input logic                             result_valid_i,
   input logic                             result_credit_i,
   input logic [1:0][$clog2(NUM_REGS)-1:0] rd_addr_i,
   input logic                             wr_v_i,
   input logic [$clog2(NUM_REGS)-1:0]      wr_addr_i
);

   import regfile_pkg::*;

   credit_cnt_t cmd_fill;
   credit_cnt_t out_credits;

   // Shadow counts of the command buffer fill and of the consumer credits.
   always_ff @(posedge w_clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cmd_fill    <= '0;
         out_credits <= credit_cnt_t'(OUT_CREDITS);
      end
      else
      begin
         cmd_fill    <= cmd_fill + credit_cnt_t'(cmd_push_i) - credit_cnt_t'(cmd_pop_i);
         out_credits <= out_credits + credit_cnt_t'(result_credit_i)
                        - credit_cnt_t'(result_valid_i);
      end
   end

   a_cmd_no_overflow: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      cmd_push_i |-> (cmd_fill < credit_cnt_t'(CMD_DEPTH)))
      else $error("Command pushed into a full buffer.");

   // The sender spends a credit one cycle before the record shows up.
   a_result_has_credit: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      result_valid_i |-> (out_credits != '0))
      else $error("Result sent without a consumer credit.");

   // Read addresses only matter in a cycle that issues a command.
   a_rd_addr_range: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      cmd_pop_i |-> ((rd_addr_i[0] < NUM_REGS) && (rd_addr_i[1] < NUM_REGS)))
      else $error("Read address out of range.");

   a_wr_addr_range: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      wr_v_i |-> (wr_addr_i < NUM_REGS))
      else $error("Write address out of range.");

endmodule

bind regfile_engine_top regfile_engine_sva
#(
   .NUM_REGS    (NUM_REGS),
   .CMD_DEPTH   (CMD_DEPTH),
   .OUT_CREDITS (OUT_CREDITS)
)
sva_i
(
   .w_clk_i         (w_clk_i),
   .arst_n_i        (arst_n_i),
   .cmd_push_i      (cmd_valid_i),
   .cmd_pop_i       (cmd_pop),
   .result_valid_i  (result_valid_o),
   .result_credit_i (result_credit_i),
   .rd_addr_i       (rd_addr),
   .wr_v_i          (wr_v[0]),
   .wr_addr_i       (wr_addr[0])
);

/* testbench/regfile_engine_tb.sv */
`timescale 1ns/1ps

module regfile_engine_tb;

   import regfile_pkg::*;

   localparam int CMD_DEPTH      = 4;
   localparam int RES_DEPTH      = 4;
   localparam int OUT_CREDITS    = 2;
   localparam int N_RAND         = 48;
   localparam int N_CHAIN        = 16;
   localparam int N_HOLD         = 12;
   localparam int N_CMDS         = NUM_REGS_DEF + N_RAND + N_CHAIN + N_HOLD;
   localparam int TIMEOUT_CYCLES = 40 * N_CMDS + 200;

   logic        w_clk_i = 1'b0;
   logic        arst_n_i;
   logic        cmd_valid_i;
   cmd_t        cmd_i;
   logic        cmd_credit_o;
   logic        result_valid_o;
   result_t     result_o;
   logic        result_credit_i;

   int          seed;
   int          cycle_cnt = 0;
   int          results_seen = 0;
   logic        hold_credits;
   credit_cnt_t host_credits;
   cmd_t        tx_q[$];
   result_t     exp_q[$];
   int          due_q[$];
   logic [DATA_W_DEF-1:0] model_regs [NUM_REGS_DEF];

   regfile_engine_top
   #(
      .DATA_W      (DATA_W_DEF),
      .NUM_REGS    (NUM_REGS_DEF),
      .CMD_DEPTH   (CMD_DEPTH),
      .RES_DEPTH   (RES_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   )
   dut_i
   (
      .w_clk_i         (w_clk_i),
      .arst_n_i        (arst_n_i),
      .cmd_valid_i     (cmd_valid_i),
      .cmd_i           (cmd_i),
      .cmd_credit_o    (cmd_credit_o),
      .result_valid_o  (result_valid_o),
      .result_o        (result_o),
      .result_credit_i (result_credit_i)
   );

   always #10 w_clk_i = ~w_clk_i;

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "Stopped at the first error.");
   endtask

   task automatic check_result(input result_t got, input result_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH at %0t: result rd %0d value %h, expected rd %0d value %h",
                  $time, got.rd, got.value, exp.rd, exp.value);
         abort_run();
      end
   endtask

   task automatic check_credits(input credit_cnt_t got, input credit_cnt_t exp,
                                input string what);
      if (got !== exp)
      begin
         $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   // Expected record from the four operation rules and the model registers.
   function automatic result_t ref_result(input cmd_t c);
      result_t r;
      logic [DATA_W_DEF-1:0] a;
      logic [DATA_W_DEF-1:0] b;
      a    = model_regs[c.rs1];
      b    = model_regs[c.rs2];
      r.rd = c.rd;
      case (c.op)
         OP_ADD:  r.value = a + b;
         OP_SUB:  r.value = a - b;
         OP_XOR:  r.value = a ^ b;
         default: r.value = c.imm;
      endcase
      return r;
   endfunction

   task automatic send_cmd(input cmd_t c);
      result_t r;
      r = ref_result(c);
      model_regs[c.rd] = r.value;
      exp_q.push_back(r);
      tx_q.push_back(c);
   endtask

   function automatic cmd_t random_alu_cmd();
      cmd_t c;
      c.op  = op_e'(2'($unsigned($random(seed)) % 3));
      c.rd  = REG_ADDR_W'($random(seed));
      c.rs1 = REG_ADDR_W'($random(seed));
      c.rs2 = REG_ADDR_W'($random(seed));
      c.imm = DATA_W_DEF'($random(seed));
      return c;
   endfunction

   task automatic wait_drained();
      @(posedge w_clk_i);
      while (tx_q.size() != 0 || exp_q.size() != 0 || due_q.size() != 0 || result_credit_i)
      begin
         @(posedge w_clk_i);
      end
   endtask

   // Host side. Commands go out only while the host holds a credit.
   always @(negedge w_clk_i)
   begin
      if (arst_n_i)
      begin
         if (cmd_credit_o)
         begin
            host_credits++;
         end
         if (tx_q.size() != 0 && host_credits != '0)
         begin
            cmd_i       = tx_q.pop_front();
            cmd_valid_i = 1'b1;
            host_credits--;
         end
         else
         begin
            cmd_valid_i = 1'b0;
         end
      end
   end

   // Consumer side returns one credit per record after 0 to 6 cycles.
   always @(negedge w_clk_i)
   begin : consumer_b
      int delay;
      if (arst_n_i)
      begin
         if (result_valid_o)
         begin
            delay = $unsigned($random(seed)) % 7;
            due_q.push_back(cycle_cnt + delay);
         end
         if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycle_cnt)
         begin
            void'(due_q.pop_front());
            result_credit_i = 1'b1;
         end
         else
         begin
            result_credit_i = 1'b0;
         end
      end
   end

   always @(negedge w_clk_i)
   begin
      if (arst_n_i && result_valid_o)
      begin
         if (exp_q.size() == 0)
         begin
            $display("A result appeared at %0t with no command outstanding.", $time);
            abort_run();
         end
         else
         begin
            check_result(result_o, exp_q.pop_front());
            results_seen++;
         end
      end
   end

   always @(posedge w_clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   initial
   begin
      cmd_t c;
      int   held_base;
      logic [REG_ADDR_W-1:0] prev_rd;
      seed            = 62545;
      arst_n_i        = 1'b0;
      cmd_valid_i     = 1'b0;
      cmd_i           = '0;
      result_credit_i = 1'b0;
      hold_credits    = 1'b0;
      host_credits    = credit_cnt_t'(CMD_DEPTH);
      repeat (16) @(posedge w_clk_i);
      @(negedge w_clk_i);
      arst_n_i = 1'b1;

      // Both outputs stay quiet while nothing has been sent.
      repeat (20)
      begin
         @(negedge w_clk_i);
         if (result_valid_o || cmd_credit_o)
         begin
            $display("An output went high at %0t before any command was sent.", $time);
            abort_run();
         end
      end
      @(posedge w_clk_i);

      for (int r = 0; r < NUM_REGS_DEF; r++)
      begin
         c     = '0;
         c.op  = OP_LOADI;
         c.rd  = REG_ADDR_W'(r);
         c.imm = DATA_W_DEF'($random(seed));
         send_cmd(c);
      end
      for (int i = 0; i < N_RAND; i++)
      begin
         send_cmd(random_alu_cmd());
      end
      wait_drained();

      // Each command reads the register that the one before it wrote.
      prev_rd = c.rd;
      for (int i = 0; i < N_CHAIN; i++)
      begin
         c       = random_alu_cmd();
         c.rs1   = prev_rd;
         prev_rd = c.rd;
         send_cmd(c);
      end
      wait_drained();

      hold_credits = 1'b1;
      held_base    = results_seen;
      for (int i = 0; i < N_HOLD; i++)
      begin
         send_cmd(random_alu_cmd());
      end
      repeat (100) @(posedge w_clk_i);
      check_credits(credit_cnt_t'(results_seen - held_base), credit_cnt_t'(OUT_CREDITS),
                    "results sent while credits were withheld");
      hold_credits = 1'b0;
      wait_drained();

      repeat (4) @(posedge w_clk_i);
      check_credits(host_credits, credit_cnt_t'(CMD_DEPTH), "command credits at the host");
      $display("all tests passed");
      $finish;
   end

endmodule

/* sources.f */
hdl/regfile_pkg.sv
hdl/reg_mem_multiport.sv
hdl/credit_fifo.sv
hdl/cmd_issue.sv
hdl/result_sender.sv
hdl/regfile_engine_top.sv
testbench/regfile_engine_sva.sv
testbench/regfile_engine_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module regfile_engine_tb \
   -f sources.f \
   -Mdir obj_dir
if [ $? -ne 0 ]
then
   echo "Verilator build failed."
   exit 1
fi

./obj_dir/Vregfile_engine_tb
if [ $? -ne 0 ]
then
   echo "Simulation ended with an error."
   exit 1
fi

exit 0
